// File: hw/video_pkg.sv
`default_nettype none

package video_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths of the raster and colour paths
	//////////////////////////////////////////////////////////////////////

	// Counters cover up to 512 columns and lines
	localparam int unsigned HCOUNT_W  = 9;
	localparam int unsigned VCOUNT_W  = 9;
	// One colour channel, and the packed RGB palette word
	localparam int unsigned CHAN_W    = 8;
	localparam int unsigned RGB_W     = 3 * CHAN_W;
	localparam int unsigned PAL_IDX_W = 4;

	typedef logic [HCOUNT_W-1:0]  hcount_t;
	typedef logic [VCOUNT_W-1:0]  vcount_t;
	typedef logic [CHAN_W-1:0]    chan_t;
	typedef logic [PAL_IDX_W-1:0] pal_idx_t;
	typedef logic [RGB_W-1:0]     rgb24_t;

	//////////////////////////////////////////////////////////////////////
	// Display processor palette
	//////////////////////////////////////////////////////////////////////

	// Packed as R in 23:16, G in 15:8, B in 7:0
	// Entry 0 is transparent, shown as black here
	localparam rgb24_t PALETTE [16] = '{
		24'h000000, 24'h000000, 24'h21c842, 24'h5edc78,
		24'h5455ed, 24'h7d76fc, 24'hd4524d, 24'h42ebf5,
		24'hfc5554, 24'hff7978, 24'hd4c154, 24'he6ce80,
		24'h21b03b, 24'hc95bba, 24'hcccccc, 24'hffffff
	};

	// Border colour, dark blue
	localparam pal_idx_t PAL_BORDER = 4'd4;

endpackage

`default_nettype wire

// File: hw/osd_cfg_pkg.sv
`default_nettype none

package osd_cfg_pkg;

	// Option word as delivered by the OSD menu
	typedef logic [31:0] status_t;

	// Option fields
	typedef logic [1:0] ar_mode_t;
	typedef logic [2:0] scan_fx_t;
	typedef logic [1:0] scale_t;

	//////////////////////////////////////////////////////////////////////
	// Bit positions inside the status word
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned STAT_RESET    = 0;
	// Aspect mode
	localparam int unsigned STAT_AR_LO    = 1;
	localparam int unsigned STAT_AR_HI    = 2;
	localparam int unsigned STAT_BORDER   = 3;
	// Scandoubler effect
	localparam int unsigned STAT_FX_LO    = 7;
	localparam int unsigned STAT_FX_HI    = 9;
	// Scaler mode
	localparam int unsigned STAT_SCALE_LO = 10;
	localparam int unsigned STAT_SCALE_HI = 11;

	// Effect codes
	// Code 1 selects HQ2x in the scaler and needs no darkening here
	localparam scan_fx_t FX_NONE  = 3'd0;
	localparam scan_fx_t FX_CRT25 = 3'd2;
	localparam scan_fx_t FX_CRT50 = 3'd3;

endpackage

`default_nettype wire

// File: hw/pixel_ce_gen.sv
`default_nettype none

module pixel_ce_gen #(
	parameter int CE_DIV = 4
) (
	input  wire  CLK_VIDEO,
	input  wire  rst_n,
	output logic ce_pix
);

	// Counter width, at least one bit
	localparam int CW = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;

	// Last count before the wrap
	localparam logic [CW-1:0] LAST = CW'(CE_DIV - 1);

	logic [CW-1:0] div_cnt;
	logic          wrap;

	// Wrap point of the modulo counter
	assign wrap = (div_cnt == LAST);

	// Free running divider
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (wrap) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Registered strobe
	// First pulse lands CE_DIV clocks after reset release
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			ce_pix <= 1'b0;
		end else begin
			ce_pix <= wrap;
		end
	end

endmodule

`default_nettype wire

// File: hw/vdp_raster.sv
`default_nettype none

module vdp_raster #(
	parameter int H_TOTAL  = 342,
	parameter int V_TOTAL  = 262,
	parameter int BORDER_W = 8
) (
	input  wire              CLK_VIDEO,
	input  wire              rst_n,
	input  wire              ce_pix,
	input  wire              border,
	output video_pkg::chan_t r,
	output video_pkg::chan_t g,
	output video_pkg::chan_t b,
	output logic             hsync_n,
	output logic             vsync_n,
	output logic             hblank,
	output logic             vblank,
	output logic             line_odd
);

	import video_pkg::*;

	// Active picture size
	localparam int PIC_W = 256;
	localparam int PIC_H = 192;

	// Sync pulse positions, both inclusive
	localparam int HS_START = 300;
	localparam int HS_END   = 325;
	localparam int VS_START = 232;
	localparam int VS_END   = 234;

	hcount_t  hcnt;
	vcount_t  vcnt;

	logic     in_pic_h;
	logic     in_pic_v;
	logic     in_win_h;
	logic     in_win_v;
	logic     act_h;
	logic     act_v;
	logic     hs_act;
	logic     vs_act;
	pal_idx_t pat_idx;
	rgb24_t   pix;

	//////////////////////////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (ce_pix) begin
			if (hcnt == hcount_t'(H_TOTAL - 1)) begin
				hcnt <= '0;
				// End of line, step the line counter
				if (vcnt == vcount_t'(V_TOTAL - 1)) begin
					vcnt <= '0;
				end else begin
					vcnt <= vcnt + 1'b1;
				end
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Region decode and pattern
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Picture proper
		in_pic_h = (hcnt < hcount_t'(PIC_W));
		in_pic_v = (vcnt < vcount_t'(PIC_H));
		// Picture plus border, the left and top parts sit before the wrap
		in_win_h = (hcnt < hcount_t'(PIC_W + BORDER_W)) ||
		           (hcnt >= hcount_t'(H_TOTAL - BORDER_W));
		in_win_v = (vcnt < vcount_t'(PIC_H + BORDER_W)) ||
		           (vcnt >= vcount_t'(V_TOTAL - BORDER_W));
		// Visible window follows the border option
		act_h = border ? in_win_h : in_pic_h;
		act_v = border ? in_win_v : in_pic_v;

		// Checker of 16x16 tiles across the palette
		pat_idx = hcnt[7:4] ^ vcnt[7:4];

		if (in_pic_h && in_pic_v) begin
			pix = PALETTE[pat_idx];
		end else if (act_h && act_v) begin
			pix = PALETTE[PAL_BORDER];
		end else begin
			// Blanking is black
			pix = '0;
		end

		hs_act = (hcnt >= hcount_t'(HS_START)) && (hcnt <= hcount_t'(HS_END));
		vs_act = (vcnt >= vcount_t'(VS_START)) && (vcnt <= vcount_t'(VS_END));
	end

	// Output register, one update per pixel
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			r        <= '0;
			g        <= '0;
			b        <= '0;
			hsync_n  <= 1'b1;
			vsync_n  <= 1'b1;
			hblank   <= 1'b1;
			vblank   <= 1'b1;
			line_odd <= 1'b0;
		end else if (ce_pix) begin
			r        <= chan_t'(pix[23:16]);
			g        <= chan_t'(pix[15:8]);
			b        <= chan_t'(pix[7:0]);
			hsync_n  <= !hs_act;
			vsync_n  <= !vs_act;
			hblank   <= !act_h;
			vblank   <= !act_v;
			line_odd <= vcnt[0];
		end
	end

endmodule

`default_nettype wire

// File: hw/sync_align.sv
`default_nettype none

module sync_align (
	input  wire              CLK_VIDEO,
	input  wire              rst_n,
	input  wire              hsync_n,
	input  wire              vsync_n,
	input  wire              hblank,
	input  wire              vblank,
	input  wire              line_odd,
	input  wire video_pkg::chan_t r_in,
	input  wire video_pkg::chan_t g_in,
	input  wire video_pkg::chan_t b_in,
	output logic             hs,
	output logic             vs,
	output logic             de,
	output logic             line_odd_o,
	output video_pkg::chan_t r,
	output video_pkg::chan_t g,
	output video_pkg::chan_t b
);

	import video_pkg::*;

	// Leading edge of horizontal sync
	// Old sample still low, new sync already active
	logic hs_rise;

	assign hs_rise = !hs && !hsync_n;

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			hs         <= 1'b0;
			vs         <= 1'b0;
			de         <= 1'b0;
			line_odd_o <= 1'b0;
			r          <= '0;
			g          <= '0;
			b          <= '0;
		end else begin
			// Positive sync for the scaler
			hs <= !hsync_n;
			// Vertical sync moves only on the hsync leading edge
			if (hs_rise) begin
				vs <= !vsync_n;
			end
			de         <= !(hblank || vblank);
			line_odd_o <= line_odd;
			// Colour follows with the same delay
			r <= chan_t'(r_in);
			g <= chan_t'(g_in);
			b <= chan_t'(b_in);
		end
	end

endmodule

`default_nettype wire

// File: hw/scanline_fx.sv
`default_nettype none

module scanline_fx (
	input  wire                   CLK_VIDEO,
	input  wire                   rst_n,
	input  wire osd_cfg_pkg::scan_fx_t fx,
	input  wire                   hs_in,
	input  wire                   vs_in,
	input  wire                   de_in,
	input  wire                   line_odd,
	input  wire video_pkg::chan_t r_in,
	input  wire video_pkg::chan_t g_in,
	input  wire video_pkg::chan_t b_in,
	output video_pkg::chan_t      vga_r,
	output video_pkg::chan_t      vga_g,
	output video_pkg::chan_t      vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_de
);

	import video_pkg::*;
	import osd_cfg_pkg::*;

	// Darkening of one channel
	// Only odd lines are touched, even lines pass as they are
	function automatic chan_t shade(input chan_t c, input scan_fx_t mode, input logic odd);
		chan_t res;
		res = c;
		if (odd) begin
			case (mode)
				// Three quarters of the level
				FX_CRT25: res = c - (c >> 2);
				// Half level, truncated
				FX_CRT50: res = c >> 1;
				default:  res = c;
			endcase
		end
		return res;
	endfunction

	chan_t r_fx;
	chan_t g_fx;
	chan_t b_fx;

	assign r_fx = shade(r_in, fx, line_odd);
	assign g_fx = shade(g_in, fx, line_odd);
	assign b_fx = shade(b_in, fx, line_odd);

	// Final output register toward the scaler
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else begin
			vga_r  <= r_fx;
			vga_g  <= g_fx;
			vga_b  <= b_fx;
			vga_hs <= hs_in;
			vga_vs <= vs_in;
			vga_de <= de_in;
		end
	end

endmodule

`default_nettype wire

// File: hw/aspect_ctrl.sv
`default_nettype none

module aspect_ctrl (
	input  wire                        CLK_VIDEO,
	input  wire                        rst_n,
	input  wire osd_cfg_pkg::status_t  status,
	input  wire [11:0]                 hdmi_width,
	input  wire [11:0]                 hdmi_height,
	input  wire                        forced_scandoubler,
	output logic [12:0]                video_arx,
	output logic [12:0]                video_ary,
	output logic [9:0]                 crop_size,
	output logic [1:0]                 vga_sl,
	output logic                       border,
	output osd_cfg_pkg::scan_fx_t      fx
);

	import osd_cfg_pkg::*;

	ar_mode_t ar;
	scan_fx_t fx_sel;
	scan_fx_t sl_full;
	logic     stat_border;
	logic     is_1080p;
	logic     en216p;

	// Field extraction
	assign ar          = status[STAT_AR_HI:STAT_AR_LO];
	assign fx_sel      = status[STAT_FX_HI:STAT_FX_LO];
	assign stat_border = status[STAT_BORDER];

	// Scanline code is the effect less one
	assign sl_full  = (fx_sel == FX_NONE) ? 3'd0 : fx_sel - 3'd1;

	// 216 line crop for a plain 1080p output
	assign is_1080p = (hdmi_width == 12'd1920) && (hdmi_height == 12'd1080);
	assign en216p   = is_1080p && (fx_sel == FX_NONE) && !forced_scandoubler;

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			video_arx <= '0;
			video_ary <= '0;
			crop_size <= '0;
			vga_sl    <= '0;
			border    <= 1'b0;
			fx        <= FX_NONE;
		end else begin
			// Mode 0 is the native 4:3, other modes pass a code to the scaler
			video_arx <= (ar == 2'd0) ? 13'd4 : {11'd0, ar - 2'd1};
			video_ary <= (ar == 2'd0) ? 13'd3 : 13'd0;
			crop_size <= en216p ? 10'd216 : 10'd0;
			vga_sl    <= sl_full[1:0];
			// Options for the pipeline stages
			border    <= stat_border;
			fx        <= fx_sel;
		end
	end

endmodule

`default_nettype wire

// File: hw/video_core_top.sv
`default_nettype none

module video_core_top #(
	parameter int CE_DIV   = 4,
	parameter int H_TOTAL  = 342,
	parameter int V_TOTAL  = 262,
	parameter int BORDER_W = 8
) (
	input  wire                       CLK_VIDEO,
	input  wire                       rst_n,
	input  wire osd_cfg_pkg::status_t status,
	input  wire [11:0]                hdmi_width,
	input  wire [11:0]                hdmi_height,
	input  wire                       forced_scandoubler,
	output logic                      ce_pix,
	output video_pkg::chan_t          vga_r,
	output video_pkg::chan_t          vga_g,
	output video_pkg::chan_t          vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      vga_de,
	output logic [1:0]                vga_sl,
	output logic [12:0]               video_arx,
	output logic [12:0]               video_ary,
	output logic [9:0]                crop_size
);

	import video_pkg::*;
	import osd_cfg_pkg::*;

	// Options from the decoder
	logic     border;
	scan_fx_t fx;

	// Raster stage outputs
	chan_t ras_r;
	chan_t ras_g;
	chan_t ras_b;
	logic  ras_hsync_n;
	logic  ras_vsync_n;
	logic  ras_hblank;
	logic  ras_vblank;
	logic  ras_line_odd;

	// Aligned stage outputs
	chan_t al_r;
	chan_t al_g;
	chan_t al_b;
	logic  al_hs;
	logic  al_vs;
	logic  al_de;
	logic  al_line_odd;

	//////////////////////////////////////////////////////////////////////
	// Pixel pipeline
	//////////////////////////////////////////////////////////////////////

	pixel_ce_gen #(
		.CE_DIV (CE_DIV)
	) pixel_ce_gen_i (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix)
	);

	vdp_raster #(
		.H_TOTAL  (H_TOTAL),
		.V_TOTAL  (V_TOTAL),
		.BORDER_W (BORDER_W)
	) vdp_raster_i (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.ce_pix    (ce_pix),
		.border    (border),
		.r         (ras_r),
		.g         (ras_g),
		.b         (ras_b),
		.hsync_n   (ras_hsync_n),
		.vsync_n   (ras_vsync_n),
		.hblank    (ras_hblank),
		.vblank    (ras_vblank),
		.line_odd  (ras_line_odd)
	);

	sync_align sync_align_i (
		.CLK_VIDEO  (CLK_VIDEO),
		.rst_n      (rst_n),
		.hsync_n    (ras_hsync_n),
		.vsync_n    (ras_vsync_n),
		.hblank     (ras_hblank),
		.vblank     (ras_vblank),
		.line_odd   (ras_line_odd),
		.r_in       (ras_r),
		.g_in       (ras_g),
		.b_in       (ras_b),
		.hs         (al_hs),
		.vs         (al_vs),
		.de         (al_de),
		.line_odd_o (al_line_odd),
		.r          (al_r),
		.g          (al_g),
		.b          (al_b)
	);

	scanline_fx scanline_fx_i (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.fx        (fx),
		.hs_in     (al_hs),
		.vs_in     (al_vs),
		.de_in     (al_de),
		.line_odd  (al_line_odd),
		.r_in      (al_r),
		.g_in      (al_g),
		.b_in      (al_b),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs),
		.vga_de    (vga_de)
	);

	// Configuration decode, beside the pipeline
	aspect_ctrl aspect_ctrl_i (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst_n              (rst_n),
		.status             (status),
		.hdmi_width         (hdmi_width),
		.hdmi_height        (hdmi_height),
		.forced_scandoubler (forced_scandoubler),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.crop_size          (crop_size),
		.vga_sl             (vga_sl),
		.border             (border),
		.fx                 (fx)
	);

endmodule

`default_nettype wire

// File: tb/video_core_props.sv
`default_nettype none

module video_core_props (
	input wire CLK_VIDEO,
	input wire rst_n,
	input wire hs,
	input wire vs,
	input wire de,
	input wire ce_pix
);

	//////////////////////////////////////////////////////////////////////
	// Sync and enable rules
	//////////////////////////////////////////////////////////////////////

	// Vertical sync moves only together with the hsync leading edge
	vs_on_hs_rise: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		$changed(vs) |-> $rose(hs))
		else $error("vs changed away from the hs leading edge");

	// No active picture while a sync pulse runs
	de_outside_sync: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		!(de && (hs || vs)))
		else $error("de high during sync");

	// Pixel strobe lasts a single clock
	ce_single: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		ce_pix |=> !ce_pix)
		else $error("ce_pix high for two clocks in a row");

endmodule

// Aligned syncs and enable, strobe tied off
bind sync_align video_core_props sync_props_i (
	.CLK_VIDEO (CLK_VIDEO),
	.rst_n     (rst_n),
	.hs        (hs),
	.vs        (vs),
	.de        (de),
	.ce_pix    (1'b0)
);

// Pixel strobe only, syncs tied off
bind pixel_ce_gen video_core_props ce_props_i (
	.CLK_VIDEO (CLK_VIDEO),
	.rst_n     (rst_n),
	.hs        (1'b0),
	.vs        (1'b0),
	.de        (1'b0),
	.ce_pix    (ce_pix)
);

`default_nettype wire

// File: tb/tb_video_core.sv
`default_nettype none

module tb_video_core;

	import video_pkg::*;
	import osd_cfg_pkg::*;

	localparam int CE_DIV   = 4;
	localparam int H_TOTAL  = 342;
	localparam int V_TOTAL  = 262;
	localparam int BORDER_W = 8;
	// Frames run after reset, the first one is partial
	localparam int FRAMES     = 6;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * CE_DIV;
	localparam int TIMEOUT    = FRAMES * FRAME_CLKS + 20000;
	// Settings change on this line, deep in vertical blanking
	localparam int SWITCH_LINE = 220;

	logic        CLK_VIDEO = 1'b0;
	logic        rst_n;
	status_t     status;
	logic [11:0] hdmi_width;
	logic [11:0] hdmi_height;
	logic        forced_scandoubler;
	logic        ce_pix;
	chan_t       vga_r;
	chan_t       vga_g;
	chan_t       vga_b;
	logic        vga_hs;
	logic        vga_vs;
	logic        vga_de;
	logic [1:0]  vga_sl;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic [9:0]  crop_size;

	integer seed = 32'hc217;
	int     checks = 0;
	int     errors = 0;
	int     err_mark;
	int     cyc = 0;
	int     last_ce = 0;
	int     fr;

	// Reference raster
	int          mh = 0;
	int          mv = 0;
	logic        vs_m = 1'b0;
	logic        cur_border;
	scan_fx_t    cur_fx;
	int          line_mark = 0;
	logic [23:0] rgb;
	logic [26:0] exp_pix;
	int          exp_h;
	logic [26:0] exp_q[$];
	int          h_q[$];
	int          due_q[$];

	// Geometry counters on the DUT output
	int line_de = 0;
	int act_lines = 0;
	int frame_de = 0;

	// Next input set
	status_t     new_st;
	logic [11:0] new_w;
	logic [11:0] new_h;
	logic        new_fs;

	video_core_top #(
		.CE_DIV   (CE_DIV),
		.H_TOTAL  (H_TOTAL),
		.V_TOTAL  (V_TOTAL),
		.BORDER_W (BORDER_W)
	) video_core_top_i (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst_n              (rst_n),
		.status             (status),
		.hdmi_width         (hdmi_width),
		.hdmi_height        (hdmi_height),
		.forced_scandoubler (forced_scandoubler),
		.ce_pix             (ce_pix),
		.vga_r              (vga_r),
		.vga_g              (vga_g),
		.vga_b              (vga_b),
		.vga_hs             (vga_hs),
		.vga_vs             (vga_vs),
		.vga_de             (vga_de),
		.vga_sl             (vga_sl),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.crop_size          (crop_size)
	);

	always #5 CLK_VIDEO = ~CLK_VIDEO;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference pixel rules
	//////////////////////////////////////////////////////////////////////

	// Visible window, picture plus the optional border on each side
	function automatic logic in_window(input int h, input int v, input logic brd);
		logic ah;
		logic av;
		ah = (h < 256) || (brd && ((h < 256 + BORDER_W) || (h >= H_TOTAL - BORDER_W)));
		av = (v < 192) || (brd && ((v < 192 + BORDER_W) || (v >= V_TOTAL - BORDER_W)));
		return ah && av;
	endfunction

	function automatic logic [23:0] expected_rgb(input int h, input int v, input logic brd);
		int idx;
		idx = ((h / 16) % 16) ^ ((v / 16) % 16);
		if ((h < 256) && (v < 192))
			return PALETTE[idx];
		if (in_window(h, v, brd))
			return PALETTE[4];
		return 24'h000000;
	endfunction

	// CRT darkening on odd lines
	function automatic logic [7:0] darken(input logic [7:0] c, input int fx, input logic odd);
		int ci;
		ci = c;
		if (!odd)
			return c;
		case (fx)
			2: return 8'(ci - ci / 4);
			3: return 8'(ci / 2);
			default: return c;
		endcase
	endfunction

	// Controls and colour all quiet
	task automatic check_idle();
		check_value("ce_pix", ce_pix, 0);
		check_value("vga_hs", vga_hs, 0);
		check_value("vga_vs", vga_vs, 0);
		check_value("vga_de", vga_de, 0);
		check_value("vga_r", vga_r, 0);
		check_value("vga_g", vga_g, 0);
		check_value("vga_b", vga_b, 0);
		check_value("video_arx", video_arx, 0);
		check_value("crop_size", crop_size, 0);
	endtask

	// idx below zero gives a free random word for the decode checks
	task automatic draw_inputs(input int idx);
		new_st = $random(seed);
		if (idx >= 0) begin
			new_st[3]   = idx % 2;
			new_st[9:7] = (idx < 4) ? 3'(idx) : 3'($random(seed));
		end else if ($random(seed) & 1) begin
			new_st[9:7] = 3'd0;
		end
		if ($random(seed) & 1) begin
			new_w = 12'd1920;
			new_h = 12'd1080;
		end else begin
			new_w = 12'($random(seed));
			new_h = 12'($random(seed));
		end
		new_fs = $random(seed);
	endtask

	// Scaler outputs one clock after the inputs move
	task automatic drive_and_check();
		int ar;
		int fxv;
		@(posedge CLK_VIDEO);
		status             <= new_st;
		hdmi_width         <= new_w;
		hdmi_height        <= new_h;
		forced_scandoubler <= new_fs;
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		ar  = new_st[2:1];
		fxv = new_st[9:7];
		check_value("video_arx", video_arx, (ar == 0) ? 4 : ar - 1);
		check_value("video_ary", video_ary, (ar == 0) ? 3 : 0);
		check_value("crop_size", crop_size,
			((new_w == 1920) && (new_h == 1080) && (fxv == 0) && !new_fs) ? 216 : 0);
		check_value("vga_sl", vga_sl, (fxv == 0) ? 0 : (fxv - 1) % 4);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Model stepped on the observed strobe, outputs sampled mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge CLK_VIDEO) begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("timeout after %0d clocks, the frames never completed", cyc);
			$display("*** FAILED ***");
			$finish;
		end else if (!rst_n) begin
			// Release lands before the next falling edge
			last_ce = cyc + 1;
		end else begin
			if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
				exp_pix = exp_q.pop_front();
				exp_h   = h_q.pop_front();
				void'(due_q.pop_front());
				// New line, close the width count of the last one
				if (exp_h == 0) begin
					if (line_de != 0) begin
						check_value("vga_de pixels per line", line_de, cur_border ? 272 : 256);
						act_lines = act_lines + 1;
					end
					line_de = 0;
				end
				check_value("vga_de", vga_de, exp_pix[26]);
				check_value("vga_hs", vga_hs, exp_pix[25]);
				check_value("vga_vs", vga_vs, exp_pix[24]);
				check_value("vga_r", vga_r, exp_pix[23:16]);
				check_value("vga_g", vga_g, exp_pix[15:8]);
				check_value("vga_b", vga_b, exp_pix[7:0]);
				if (vga_de) begin
					line_de  = line_de + 1;
					frame_de = frame_de + 1;
				end
			end
			if (ce_pix) begin
				check_value("ce_pix spacing", cyc - last_ce, CE_DIV);
				last_ce = cyc;
				// Vertical sync sampled at the hsync leading edge
				if (mh == 300)
					vs_m = (mv >= 232) && (mv <= 234);
				rgb = expected_rgb(mh, mv, cur_border);
				exp_pix = {in_window(mh, mv, cur_border), (mh >= 300) && (mh <= 325), vs_m,
					darken(rgb[23:16], cur_fx, mv[0]), darken(rgb[15:8], cur_fx, mv[0]),
					darken(rgb[7:0], cur_fx, mv[0])};
				exp_q.push_back(exp_pix);
				h_q.push_back(mh);
				due_q.push_back(cyc + 3);
				mh = (mh == H_TOTAL - 1) ? 0 : mh + 1;
				if (mh == 0)
					mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
				if ((mh == 0) && (mv == SWITCH_LINE))
					line_mark = line_mark + 1;
			end
		end
	end

	initial begin
		rst_n <= 1'b0;
		draw_inputs(0);
		status             <= new_st;
		hdmi_width         <= new_w;
		hdmi_height        <= new_h;
		forced_scandoubler <= new_fs;
		cur_border = new_st[3];
		cur_fx     = new_st[9:7];
		repeat (8) @(negedge CLK_VIDEO);
		check_idle();
		@(posedge CLK_VIDEO);
		rst_n <= 1'b1;
		@(negedge CLK_VIDEO);
		check_idle();
		$display("reset state: %0d errors", errors);
		err_mark = errors;
		for (fr = 0; fr < FRAMES; fr++) begin
			wait (line_mark == fr + 1);
			// Frame 0 starts at line 0 and misses the top border
			check_value("active lines", act_lines,
				cur_border ? ((fr == 0) ? 200 : 208) : 192);
			check_value("vga_de pixels per frame", frame_de,
				cur_border ? ((fr == 0) ? 272 * 200 : 272 * 208) : 256 * 192);
			$display("frame %0d: border %0b, effect %0d, %0d errors",
				fr, cur_border, cur_fx, errors - err_mark);
			err_mark  = errors;
			act_lines = 0;
			frame_de  = 0;
			repeat (6) begin
				draw_inputs(-1);
				drive_and_check();
			end
			draw_inputs(fr + 1);
			cur_border = new_st[3];
			cur_fx     = new_st[9:7];
			drive_and_check();
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hw/video_pkg.sv
hw/osd_cfg_pkg.sv
hw/pixel_ce_gen.sv
hw/vdp_raster.sv
hw/sync_align.sv
hw/scanline_fx.sv
hw/aspect_ctrl.sv
hw/video_core_top.sv
tb/video_core_props.sv
tb/tb_video_core.sv

// File: Bender.yml
package:
  name: video_core

sources:
  - target: any(synthesis, simulation)
    files:
      - hw/video_pkg.sv
      - hw/osd_cfg_pkg.sv
      - hw/pixel_ce_gen.sv
      - hw/vdp_raster.sv
      - hw/sync_align.sv
      - hw/scanline_fx.sv
      - hw/aspect_ctrl.sv
      - hw/video_core_top.sv

  - target: simulation
    files:
      - tb/video_core_props.sv
      - tb/tb_video_core.sv
